//--- include/zxuno_regs_settings.svh
`ifndef ZXUNO_REGS_SETTINGS_SVH
`define ZXUNO_REGS_SETTINGS_SVH

// ----------------------------------------------------------------------
// I/O ports of the indirect register bank
// ----------------------------------------------------------------------

// Register address select
`define ZXUNO_ADDR_PORT 16'hFC3B
// Register data access
`define ZXUNO_DATA_PORT 16'hFD3B

// ----------------------------------------------------------------------
// Register addresses
// ----------------------------------------------------------------------

`define REG_SCANDBL     8'h0B
`define REG_RASTER_LINE 8'h0C
`define REG_RASTER_CTRL 8'h0D
`define REG_DEVOPTIONS  8'h0E
`define REG_SCRATCH     8'hFE
`define REG_COREID      8'hFF

// Byte seen by the CPU when nothing drives the bus
`define OPEN_BUS_VALUE 8'hFF

// Raster line after reset, out of range so no interrupt fires
`define RASTER_LINE_RESET 9'h1FF

// Core identification, first character in the top byte
`define CORE_ID_STRING "ZXU-REGS"
`define CORE_ID_LEN    8

`endif

//--- design/zxuno_regs_pkg.sv
package zxuno_regs_pkg;

   // CPU side of the bus as seen by the register bank
   typedef struct packed {
      logic [15:0] addr;
      logic [7:0]  dout;
      logic        iorq_n;
      logic        rd_n;
      logic        wr_n;
   } cpu_bus_t;

   // Decoded access to the data port
   typedef struct packed {
      logic [7:0] addr;
      logic       rd;
      logic       wr;
      logic       regaddr_changed;
   } reg_access_t;

   // One candidate byte for the CPU data-in bus
   typedef struct packed {
      logic       oe_n;
      logic [7:0] data;
   } read_src_t;

   // Device enable options, bit 7 down to bit 0
   typedef struct packed {
      logic disable_spisd;
      logic enable_timexmmu;
      logic disable_romsel1f;
      logic disable_romsel7f;
      logic disable_1ffd;
      logic disable_7ffd;
      logic disable_turboay;
      logic disable_ay;
   } dev_options_t;

   // Scan doubler control, seen whole or split into its fields
   typedef union packed {
      logic [7:0] raw;
      struct packed {
         logic [1:0] turbo_enable;
         logic       csync_option;
         logic [2:0] freq_option;
         logic       scanlines_enable;
         logic       vga_enable;
      } fields;
   } scandbl_ctrl_u;

   // Raster interrupt setup handed to the video side
   typedef struct packed {
      logic [8:0] raster_line;
      logic       rasterint_enable;
      logic       vretraceint_disable;
   } raster_cfg_t;

endpackage

//--- design/zxuno_addr_port.sv
`timescale 1ns/1ps

`include "zxuno_regs_settings.svh"

module zxuno_addr_port
   import zxuno_regs_pkg::*;
(
   input  logic        cpuclkplain,
   input  logic        rst_n,
   input  cpu_bus_t    cpu,
   output reg_access_t acc,
   output read_src_t   rd_addr
);

   logic       addr_hit;
   logic       data_hit;
   logic       io_wr;
   logic       io_rd;
   logic       io_wr_d;
   logic       first_wr;
   logic [7:0] regaddr;
   logic       wr_pulse;
   logic       changed_pulse;

   // Full 16-bit port decode
   assign addr_hit = (cpu.addr == `ZXUNO_ADDR_PORT);
   assign data_hit = (cpu.addr == `ZXUNO_DATA_PORT);

   assign io_wr = ~cpu.iorq_n & ~cpu.wr_n;
   assign io_rd = ~cpu.iorq_n & ~cpu.rd_n;

   // Only the first cycle of a write access counts
   assign first_wr = io_wr & ~io_wr_d;

   always_ff @(posedge cpuclkplain) begin
      if (!rst_n) begin
         io_wr_d       <= 1'b0;
         regaddr       <= 8'h00;
         wr_pulse      <= 1'b0;
         changed_pulse <= 1'b0;
      end else begin
         io_wr_d       <= io_wr;
         wr_pulse      <= first_wr & data_hit;
         changed_pulse <= first_wr & addr_hit;
         if (first_wr && addr_hit) begin
            regaddr <= cpu.dout;
         end
      end
   end

   // Strobes toward the register blocks
   assign acc.addr            = regaddr;
   assign acc.rd              = io_rd & data_hit;
   assign acc.wr              = wr_pulse;
   assign acc.regaddr_changed = changed_pulse;

   // Read-back of the selected address
   assign rd_addr.oe_n = ~(io_rd & addr_hit);
   assign rd_addr.data = regaddr;

endmodule

//--- design/coreid_reader.sv
`timescale 1ns/1ps

`include "zxuno_regs_settings.svh"

module coreid_reader
   import zxuno_regs_pkg::*;
(
   input  logic        cpuclkplain,
   input  logic        rst_n,
   input  reg_access_t acc,
   output read_src_t   rd_coreid
);

   localparam int IDX_W = $clog2(`CORE_ID_LEN + 1);
   localparam logic [IDX_W-1:0] END_IDX = IDX_W'(`CORE_ID_LEN);
   localparam logic [8*`CORE_ID_LEN-1:0] ID_STR = `CORE_ID_STRING;

   logic [IDX_W-1:0] idx;
   logic             id_rd;
   logic             id_rd_d;
   logic [7:0]       id_char;

   assign id_rd = acc.rd & (acc.addr == `REG_COREID);

   // Step once when a read finishes, stop after the last character
   always_ff @(posedge cpuclkplain) begin
      if (!rst_n) begin
         idx     <= '0;
         id_rd_d <= 1'b0;
      end else begin
         id_rd_d <= id_rd;
         if (acc.regaddr_changed) begin
            idx <= '0;
         end else if (id_rd_d && !id_rd && idx < END_IDX) begin
            idx <= idx + 1'b1;
         end
      end
   end

   // Past the end the string reads as zero
   always_comb begin
      id_char = 8'h00;
      for (int i = 0; i < `CORE_ID_LEN; i++) begin
         if (idx == IDX_W'(i)) begin
            id_char = ID_STR[8*(`CORE_ID_LEN-1-i) +: 8];
         end
      end
   end

   assign rd_coreid.oe_n = ~id_rd;
   assign rd_coreid.data = id_char;

endmodule

//--- design/config_regs.sv
`timescale 1ns/1ps

`include "zxuno_regs_settings.svh"

module config_regs
   import zxuno_regs_pkg::*;
(
   input  logic          cpuclkplain,
   input  logic          rst_n,
   input  reg_access_t   acc,
   input  logic [7:0]    din,
   output dev_options_t  devopts,
   output scandbl_ctrl_u scandbl,
   output read_src_t     rd_cfg
);

   logic [7:0] scratch;
   logic       cfg_hit;
   logic [7:0] cfg_data;

   // ----------------------------------------------------------------------
   // Register writes
   // ----------------------------------------------------------------------

   always_ff @(posedge cpuclkplain) begin
      if (!rst_n) begin
         scratch     <= 8'h00;
         devopts     <= '0;
         scandbl.raw <= 8'h00;
      end else if (acc.wr) begin
         case (acc.addr)
            `REG_SCRATCH: begin
               scratch <= din;
            end
            `REG_DEVOPTIONS: begin
               devopts <= dev_options_t'(din);
            end
            `REG_SCANDBL: begin
               // Whole byte, the field view is decoded downstream
               scandbl.raw <= din;
            end
            default: begin
            end
         endcase
      end
   end

   // ----------------------------------------------------------------------
   // Read-back
   // ----------------------------------------------------------------------

   always_comb begin
      cfg_hit  = 1'b1;
      cfg_data = 8'h00;
      case (acc.addr)
         `REG_SCRATCH: begin
            cfg_data = scratch;
         end
         `REG_DEVOPTIONS: begin
            cfg_data = devopts;
         end
         `REG_SCANDBL: begin
            cfg_data = scandbl.raw;
         end
         default: begin
            cfg_hit = 1'b0;
         end
      endcase
   end

   assign rd_cfg.oe_n = ~(acc.rd & cfg_hit);
   assign rd_cfg.data = cfg_data;

endmodule

//--- design/rasterint_regs.sv
`timescale 1ns/1ps

`include "zxuno_regs_settings.svh"

module rasterint_regs
   import zxuno_regs_pkg::*;
(
   input  logic        cpuclkplain,
   input  logic        rst_n,
   input  reg_access_t acc,
   input  logic [7:0]  din,
   input  logic        raster_int_in_progress,
   output raster_cfg_t raster,
   output read_src_t   rd_raster
);

   logic       raster_hit;
   logic [7:0] raster_data;

   always_ff @(posedge cpuclkplain) begin
      if (!rst_n) begin
         raster.raster_line         <= `RASTER_LINE_RESET;
         raster.rasterint_enable    <= 1'b0;
         raster.vretraceint_disable <= 1'b0;
      end else if (acc.wr) begin
         if (acc.addr == `REG_RASTER_LINE) begin
            raster.raster_line[7:0] <= din;
         end else if (acc.addr == `REG_RASTER_CTRL) begin
            raster.raster_line[8]      <= din[0];
            raster.vretraceint_disable <= din[1];
            raster.rasterint_enable    <= din[2];
         end
      end
   end

   // Status bit 7 comes live from the video side
   always_comb begin
      raster_hit  = 1'b1;
      raster_data = 8'h00;
      if (acc.addr == `REG_RASTER_LINE) begin
         raster_data = raster.raster_line[7:0];
      end else if (acc.addr == `REG_RASTER_CTRL) begin
         raster_data = {raster_int_in_progress, 4'b0000, raster.rasterint_enable,
                        raster.vretraceint_disable, raster.raster_line[8]};
      end else begin
         raster_hit = 1'b0;
      end
   end

   assign rd_raster.oe_n = ~(acc.rd & raster_hit);
   assign rd_raster.data = raster_data;

endmodule

//--- design/bus_read_mux.sv
`timescale 1ns/1ps

`include "zxuno_regs_settings.svh"

module bus_read_mux
   import zxuno_regs_pkg::*;
(
   input  read_src_t  rd_addr,
   input  read_src_t  rd_coreid,
   input  read_src_t  rd_cfg,
   input  read_src_t  rd_raster,
   output logic [7:0] cpudin,
   output logic       cpudin_oe_n
);

   // First enabled source wins
   always_comb begin
      if (!rd_addr.oe_n) begin
         cpudin = rd_addr.data;
      end else if (!rd_coreid.oe_n) begin
         cpudin = rd_coreid.data;
      end else if (!rd_cfg.oe_n) begin
         cpudin = rd_cfg.data;
      end else if (!rd_raster.oe_n) begin
         cpudin = rd_raster.data;
      end else begin
         // Open bus
         cpudin = `OPEN_BUS_VALUE;
      end
   end

   assign cpudin_oe_n = rd_addr.oe_n & rd_coreid.oe_n & rd_cfg.oe_n & rd_raster.oe_n;

endmodule

//--- design/zxuno_regs_top.sv
`timescale 1ns/1ps

module zxuno_regs_top
   import zxuno_regs_pkg::*;
(
   input  logic          cpuclkplain,
   input  logic          rst_n,
   input  cpu_bus_t      cpu,
   input  logic          raster_int_in_progress,
   output logic [7:0]    cpudin,
   output logic          cpudin_oe_n,
   output dev_options_t  devopts,
   output scandbl_ctrl_u scandbl,
   output raster_cfg_t   raster
);

   reg_access_t acc;
   read_src_t   rd_addr;
   read_src_t   rd_coreid;
   read_src_t   rd_cfg;
   read_src_t   rd_raster;

   zxuno_addr_port addr_port_i (
      .cpuclkplain (cpuclkplain),
      .rst_n       (rst_n),
      .cpu         (cpu),
      .acc         (acc),
      .rd_addr     (rd_addr)
   );

   coreid_reader coreid_i (
      .cpuclkplain (cpuclkplain),
      .rst_n       (rst_n),
      .acc         (acc),
      .rd_coreid   (rd_coreid)
   );

   config_regs config_i (
      .cpuclkplain (cpuclkplain),
      .rst_n       (rst_n),
      .acc         (acc),
      .din         (cpu.dout),
      .devopts     (devopts),
      .scandbl     (scandbl),
      .rd_cfg      (rd_cfg)
   );

   rasterint_regs raster_i (
      .cpuclkplain            (cpuclkplain),
      .rst_n                  (rst_n),
      .acc                    (acc),
      .din                    (cpu.dout),
      .raster_int_in_progress (raster_int_in_progress),
      .raster                 (raster),
      .rd_raster              (rd_raster)
   );

   bus_read_mux read_mux_i (
      .rd_addr     (rd_addr),
      .rd_coreid   (rd_coreid),
      .rd_cfg      (rd_cfg),
      .rd_raster   (rd_raster),
      .cpudin      (cpudin),
      .cpudin_oe_n (cpudin_oe_n)
   );

endmodule

//--- dv/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
   output logic clk,
   output logic rst_n
);

   // 20 ns period
   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Reset held for five rising edges, released just after the fifth
   initial begin
      rst_n = 1'b0;
      repeat (5) @(posedge clk);
      #2;
      rst_n = 1'b1;
   end

endmodule

//--- dv/zxuno_regs_assertions.sv
`timescale 1ns/1ps

`include "zxuno_regs_settings.svh"

module zxuno_regs_assertions
   import zxuno_regs_pkg::*;
(
   input logic          cpuclkplain,
   input logic          rst_n,
   input cpu_bus_t      cpu,
   input reg_access_t   acc,
   input read_src_t     rd_addr,
   input read_src_t     rd_coreid,
   input read_src_t     rd_cfg,
   input read_src_t     rd_raster,
   input dev_options_t  devopts,
   input scandbl_ctrl_u scandbl,
   input raster_cfg_t   raster
);

   int fail_count = 0;

   // Write and address-change strobes are single-cycle pulses
   pulse_width: assert property (@(posedge cpuclkplain) disable iff (!rst_n)
      !(acc.wr && $past(acc.wr)) && !(acc.regaddr_changed && $past(acc.regaddr_changed)))
   else begin
      $error("register strobe held for more than one cycle");
      fail_count++;
   end

   // Nothing drives the data-in bus outside an I/O cycle
   idle_oe: assert property (@(posedge cpuclkplain)
      cpu.iorq_n |-> &{rd_addr.oe_n, rd_coreid.oe_n, rd_cfg.oe_n, rd_raster.oe_n})
   else begin
      $error("read source enabled while iorq_n is high");
      fail_count++;
   end

   reset_values: assert property (@(posedge cpuclkplain)
      !rst_n |=> (devopts == '0 && scandbl.raw == 8'h00 &&
                  raster == {`RASTER_LINE_RESET, 2'b00}))
   else begin
      $error("register outputs not at their reset values after reset");
      fail_count++;
   end

endmodule

bind zxuno_regs_top zxuno_regs_assertions asrt_i (.*);

//--- dv/tb_zxuno_regs.sv
`timescale 1ns/1ps

`include "zxuno_regs_settings.svh"

module tb_zxuno_regs
   import zxuno_regs_pkg::*;
();

   localparam int MAX_CASES = 64;

   logic          clk;
   logic          rst_n;
   cpu_bus_t      cpu;
   logic          raster_flag;
   logic [7:0]    cpudin;
   logic          cpudin_oe_n;
   dev_options_t  devopts;
   scandbl_ctrl_u scandbl;
   raster_cfg_t   raster;
   logic [15:0]   case_mem [0:4*MAX_CASES-1];
   int            cycles = 0;
   int            cycle_limit = 5 + 4 * MAX_CASES + 50;
   int            errors = 0;
   int            passed = 0;
   int            failed = 0;

   clk_gen clk_gen_i (
      .clk   (clk),
      .rst_n (rst_n)
   );

   zxuno_regs_top dut_i (
      .cpuclkplain            (clk),
      .rst_n                  (rst_n),
      .cpu                    (cpu),
      .raster_int_in_progress (raster_flag),
      .cpudin                 (cpudin),
      .cpudin_oe_n            (cpudin_oe_n),
      .devopts                (devopts),
      .scandbl                (scandbl),
      .raster                 (raster)
   );

   // Run limit, tightened once the case file is read
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit) begin
         $display("Timeout: the test sequence did not finish within %0d cycles", cycle_limit);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   task automatic check_value(input logic [15:0] got, input logic [15:0] exp, input string what);
      if (got !== exp) begin
         $display("[ERROR] %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
         errors++;
      end
   endtask

   // Field outputs after a data-port write, each bit at its documented position
   task automatic check_fields(input logic [7:0] reg_addr, input logic [7:0] d);
      if (reg_addr == `REG_SCANDBL) begin
         check_value({scandbl.fields.turbo_enable, scandbl.fields.csync_option,
                      scandbl.fields.freq_option, scandbl.fields.scanlines_enable,
                      scandbl.fields.vga_enable}, d, "scandbl fields");
      end else if (reg_addr == `REG_DEVOPTIONS) begin
         check_value({devopts.disable_spisd, devopts.enable_timexmmu, devopts.disable_romsel1f,
                      devopts.disable_romsel7f, devopts.disable_1ffd, devopts.disable_7ffd,
                      devopts.disable_turboay, devopts.disable_ay}, d, "devopts fields");
      end else if (reg_addr == `REG_RASTER_LINE) begin
         check_value(raster.raster_line[7:0], d, "raster_line low byte");
      end else if (reg_addr == `REG_RASTER_CTRL) begin
         check_value({raster.rasterint_enable, raster.vretraceint_disable,
                      raster.raster_line[8]}, d[2:0], "raster control fields");
      end
   endtask

   initial begin
      logic [15:0] op;
      logic [15:0] port;
      logic [7:0]  data;
      logic [7:0]  exp_byte;
      logic [7:0]  sel_reg;
      logic        exp_oe_n;
      int          num_cases;
      int          errors_before;

      cpu = '{addr: 16'h0000, dout: 8'h00, iorq_n: 1'b1, rd_n: 1'b1, wr_n: 1'b1};
      raster_flag = 1'b0;
      sel_reg = 8'h00;
      num_cases = 0;
      $readmemh("dv/zxuno_regs_cases.txt", case_mem);
      while (num_cases < MAX_CASES && case_mem[4 * num_cases] inside {16'h1, 16'h2, 16'h3}) begin
         num_cases++;
      end
      cycle_limit = 5 + 4 * num_cases + 50;
      @(posedge rst_n);
      @(posedge clk);
      #2;
      for (int n = 0; n < num_cases; n++) begin
         op = case_mem[4 * n];
         port = case_mem[4 * n + 1];
         data = case_mem[4 * n + 2][7:0];
         exp_byte = case_mem[4 * n + 3][7:0];
         errors_before = errors;
         if (op == 16'h3) begin
            raster_flag = data[0];
         end else begin
            cpu.addr = port;
            cpu.dout = data;
            cpu.iorq_n = 1'b0;
            cpu.wr_n = (op != 16'h1);
            cpu.rd_n = (op != 16'h2);
            // Sample in the middle of the last strobe cycle
            repeat (2) @(posedge clk);
            #8;
            if (op == 16'h2) begin
               exp_oe_n = (port != `ZXUNO_ADDR_PORT) && !(port == `ZXUNO_DATA_PORT &&
                  sel_reg inside {`REG_SCANDBL, `REG_RASTER_LINE, `REG_RASTER_CTRL,
                                  `REG_DEVOPTIONS, `REG_SCRATCH, `REG_COREID});
               check_value(cpudin, exp_byte, "cpudin");
               check_value(cpudin_oe_n, exp_oe_n, "cpudin_oe_n");
            end
            @(posedge clk);
            #2;
            cpu.iorq_n = 1'b1;
            cpu.rd_n = 1'b1;
            cpu.wr_n = 1'b1;
            if (op == 16'h1 && port == `ZXUNO_ADDR_PORT) begin
               sel_reg = data;
            end else if (op == 16'h1 && port == `ZXUNO_DATA_PORT) begin
               check_fields(sel_reg, data);
            end
         end
         @(posedge clk);
         #2;
         if (errors == errors_before) begin
            passed++;
         end else begin
            failed++;
         end
         $display("Case %0d: op %0h port %h data %h expect %h, %s", n, op, port, data, exp_byte,
                  (errors == errors_before) ? "ok" : "mismatch");
      end
      errors += dut_i.asrt_i.fail_count;
      $display("Cases passed %0d, failed %0d, assertion failures %0d",
               passed, failed, dut_i.asrt_i.fail_count);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

//--- dv/zxuno_regs_cases.txt
// op port data expect, op 1 write, 2 read, 3 raster flag from data bit 0, 0 ends the list
// expect is the byte a read returns, unused by the other ops
2 FC3B 00 00
2 1234 00 FF
1 FC3B 22 00
2 FD3B 00 FF
2 FC3B 00 22
1 FC3B 0C 00
2 FD3B 00 FF
1 FD3B 37 00
2 FD3B 00 37
1 FC3B 0D 00
2 FD3B 00 01
1 FD3B 06 00
2 FD3B 00 06
3 0000 01 00
2 FD3B 00 86
1 FC3B FE 00
2 FD3B 00 00
1 FD3B A5 00
2 FD3B 00 A5
1 FC3B 0E 00
2 FD3B 00 00
1 FD3B 5A 00
2 FD3B 00 5A
1 FC3B 0B 00
2 FD3B 00 00
1 FD3B C6 00
2 FD3B 00 C6
1 FC3B FF 00
2 FD3B 00 5A
2 FD3B 00 58
2 FD3B 00 55
2 FD3B 00 2D
2 FD3B 00 52
2 FD3B 00 45
2 FD3B 00 47
2 FD3B 00 53
2 FD3B 00 00
1 FC3B FF 00
2 FD3B 00 5A
2 FD3B 00 58
0 0000 00 00

//--- build.f
+incdir+include
design/zxuno_regs_pkg.sv
design/zxuno_addr_port.sv
design/coreid_reader.sv
design/config_regs.sv
design/rasterint_regs.sv
design/bus_read_mux.sv
design/zxuno_regs_top.sv
dv/clk_gen.sv
dv/zxuno_regs_assertions.sv
dv/tb_zxuno_regs.sv

//--- Bender.yml
package:
  name: zxuno_regs

sources:
  - include_dirs:
      - include
    files:
      - design/zxuno_regs_pkg.sv
      - design/zxuno_addr_port.sv
      - design/coreid_reader.sv
      - design/config_regs.sv
      - design/rasterint_regs.sv
      - design/bus_read_mux.sv
      - design/zxuno_regs_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - dv/clk_gen.sv
      - dv/zxuno_regs_assertions.sv
      - dv/tb_zxuno_regs.sv
